//--- logic/bch_code_pkg.sv
`default_nettype none

package bch_code_pkg;

	////////////////////////////////////////
	// code dimensions
	////////////////////////////////////////

	// total bits per codeword
	localparam int CODE_N = 15;

	// message bits carried unchanged at the head of each codeword
	localparam int MSG_K = 5;

	// number of bit errors the code can correct
	localparam int CORR_T = 3;

	// degree of the extension field GF(2^m) the code is built over
	localparam int FIELD_M = 4;

	// parity bits appended after the message
	localparam int PARITY_W = CODE_N - MSG_K;

	// g(x) = x^10 + x^8 + x^5 + x^4 + x^2 + x + 1 with the x^10 term left implicit
	localparam logic [PARITY_W-1:0] GEN_POLY = 10'b01_0011_0111;

endpackage

`default_nettype wire

//--- logic/bch_stream_pkg.sv
`default_nettype none

package bch_stream_pkg;

	////////////////////////////////////////
	// position counter
	////////////////////////////////////////

	// one counter bit per field bit, so the counter period matches the codeword length
	localparam int CNT_W = bch_code_pkg::FIELD_M;

	// galois feedback for the primitive polynomial x^4 + x + 1
	localparam logic [CNT_W-1:0] CNT_TAPS = 4'b0011;

	// state held while the encoder waits for beat 1
	localparam logic [CNT_W-1:0] CNT_SEED = 4'b0001;

	// the sequence from the seed runs 1,2,4,8,3,6,c,b,5,a,7,e,f,d,9
	localparam logic [CNT_W-1:0] POS_LAST_MSG = 4'b0011;
	localparam logic [CNT_W-1:0] POS_LAST_BEAT = 4'b1001;

	// which half of the codeword is being produced
	typedef enum logic {
		phase_msg = 1'b0,
		phase_parity = 1'b1
	} enc_phase_t;

endpackage

`default_nettype wire

//--- logic/lfsr_counter.sv
`timescale 1ns/1ps
`default_nettype none

module lfsr_counter
	import bch_stream_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic restart,
	input wire logic advance,
	output logic [CNT_W-1:0] count
);

	logic [CNT_W-1:0] count_next;
	logic feedback;

	// galois form keeps the feedback to a single xor level per tap
	assign feedback = count[CNT_W-1];

	always_comb begin
		count_next = {count[CNT_W-2:0], 1'b0};
		if (feedback) begin
			count_next = count_next ^ CNT_TAPS;
		end
	end

	////////////////////////////////////////
	// state register
	////////////////////////////////////////

	// restart wins over advance so a frame always begins at the seed
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= CNT_SEED;
		end else if (restart) begin
			count <= CNT_SEED;
		end else if (advance) begin
			count <= count_next;
		end
	end

endmodule

`default_nettype wire

//--- logic/parity_lfsr.sv
`timescale 1ns/1ps
`default_nettype none

module parity_lfsr
	import bch_code_pkg::*;
	import bch_stream_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic step,
	input wire enc_phase_t phase,
	input wire logic frame_start,
	input wire logic in_data,
	output logic parity_bit
);

	logic [PARITY_W-1:0] rem_q;
	logic [PARITY_W-1:0] rem_base;
	logic [PARITY_W-1:0] rem_div;
	logic [PARITY_W-1:0] rem_shift;
	logic feedback;

	////////////////////////////////////////
	// division by g(x)
	////////////////////////////////////////

	// the first message bit starts a fresh remainder
	// so whatever the previous frame left behind is ignored
	assign rem_base = frame_start ? '0 : rem_q;

	// message bits enter at the top, which multiplies the message by x^10
	assign feedback = in_data ^ rem_base[PARITY_W-1];

	assign rem_div = {rem_base[PARITY_W-2:0], 1'b0} ^ ({PARITY_W{feedback}} & GEN_POLY);

	// after the message the remainder is just the parity, read out msb first
	assign rem_shift = {rem_q[PARITY_W-2:0], 1'b0};

	////////////////////////////////////////
	// remainder register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rem_q <= '0;
		end else if (step) begin
			if (phase == phase_msg) begin
				rem_q <= rem_div;
			end else begin
				rem_q <= rem_shift;
			end
		end
	end

	// the output stage samples this on the same step that shifts it away
	assign parity_bit = rem_q[PARITY_W-1];

endmodule

`default_nettype wire

//--- logic/frame_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer
	import bch_stream_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic in_valid,
	input wire logic slot_free,
	output logic in_ready,
	output logic step,
	output enc_phase_t phase,
	output logic frame_start,
	output logic frame_end
);

	logic [CNT_W-1:0] count;
	logic at_last_msg;
	logic at_last_beat;
	logic in_msg;
	logic restart;

	////////////////////////////////////////
	// beat decisions
	////////////////////////////////////////

	assign in_msg = (phase == phase_msg);

	// the input is only offered while message bits are wanted
	assign in_ready = in_msg & slot_free;

	// parity beats need nothing from the producer, only room downstream
	assign step = slot_free & (in_msg ? in_valid : 1'b1);

	// position compares are against single lfsr states
	assign at_last_msg = in_msg & (count == POS_LAST_MSG);
	assign at_last_beat = !in_msg & (count == POS_LAST_BEAT);

	// both flags describe the beat that the next step will carry
	assign frame_start = in_msg & (count == CNT_SEED);
	assign frame_end = at_last_beat;

	// the counter is reloaded once the final parity beat has gone
	assign restart = step & at_last_beat;

	////////////////////////////////////////
	// position counter
	////////////////////////////////////////

	lfsr_counter cnt_i (
		.clk(clk),
		.rst_n(rst_n),
		.restart(restart),
		.advance(step),
		.count(count)
	);

	////////////////////////////////////////
	// phase register
	////////////////////////////////////////

	// the phase flips on the edge that takes the last beat of each half
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase <= phase_msg;
		end else if (step) begin
			if (at_last_msg) begin
				phase <= phase_parity;
			end else if (at_last_beat) begin
				phase <= phase_msg;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/codeword_mux.sv
`timescale 1ns/1ps
`default_nettype none

module codeword_mux
	import bch_stream_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic step,
	input wire enc_phase_t phase,
	input wire logic frame_start,
	input wire logic frame_end,
	input wire logic in_data,
	input wire logic parity_bit,
	input wire logic out_ready,
	output logic slot_free,
	output logic out_valid,
	output logic out_data,
	output logic out_first,
	output logic out_last
);

	logic next_bit;

	// a full register can still take a beat when the consumer drains it now
	assign slot_free = !out_valid | out_ready;

	// systematic code, so message bits pass straight through
	assign next_bit = (phase == phase_msg) ? in_data : parity_bit;

	////////////////////////////////////////
	// handshake and markers
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_first <= 1'b0;
			out_last <= 1'b0;
		end else if (step) begin
			out_valid <= 1'b1;
			out_first <= frame_start;
			out_last <= frame_end;
		end else if (out_ready) begin
			// drained with nothing behind it
			out_valid <= 1'b0;
			out_first <= 1'b0;
			out_last <= 1'b0;
		end
	end

	////////////////////////////////////////
	// data bit
	////////////////////////////////////////

	// step is only possible when slot_free, so a stalled beat is never overwritten
	always_ff @(posedge clk) begin
		if (step) begin
			out_data <= next_bit;
		end
	end

endmodule

`default_nettype wire

//--- logic/bch_encode_top.sv
`timescale 1ns/1ps
`default_nettype none

module bch_encode_top
	import bch_stream_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic in_valid,
	input wire logic in_data,
	output logic in_ready,
	output logic out_valid,
	output logic out_data,
	output logic out_first,
	output logic out_last,
	input wire logic out_ready
);

	logic slot_free;
	logic step;
	enc_phase_t phase;
	logic frame_start;
	logic frame_end;
	logic parity_bit;

	////////////////////////////////////////
	// beat control
	////////////////////////////////////////

	frame_sequencer seq_i (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.slot_free(slot_free),
		.in_ready(in_ready),
		.step(step),
		.phase(phase),
		.frame_start(frame_start),
		.frame_end(frame_end)
	);

	////////////////////////////////////////
	// parity generation
	////////////////////////////////////////

	parity_lfsr par_i (
		.clk(clk),
		.rst_n(rst_n),
		.step(step),
		.phase(phase),
		.frame_start(frame_start),
		.in_data(in_data),
		.parity_bit(parity_bit)
	);

	////////////////////////////////////////
	// output stage
	////////////////////////////////////////

	codeword_mux mux_i (
		.clk(clk),
		.rst_n(rst_n),
		.step(step),
		.phase(phase),
		.frame_start(frame_start),
		.frame_end(frame_end),
		.in_data(in_data),
		.parity_bit(parity_bit),
		.out_ready(out_ready),
		.slot_free(slot_free),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_first(out_first),
		.out_last(out_last)
	);

endmodule

`default_nettype wire

//--- bench/bch_encode_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bch_encode_tb
	import bch_code_pkg::*;
();

	localparam int FRAMES = 32;
	localparam int PASSES = 2;
	localparam int ACCEPT_TIMEOUT = 200;
	localparam int FRAME_TIMEOUT = 4000;
	localparam logic [31:0] SEED = 32'ha17d_c2db;

	logic clk, rst_n, in_valid, in_data, in_ready;
	logic out_valid, out_data, out_first, out_last, out_ready;
	logic [23:0] golden [0:FRAMES-1];
	logic [31:0] rng_in = SEED;
	logic [31:0] rng_out = ~SEED;
	logic stall_mode = 1'b0;
	int errors = 0;
	int checks = 0;
	int in_taken = 0;
	int frames_done = 0;
	int beat_idx = 0;
	int bits_in_frame = 0;
	int low_count = 0;
	int reset_edges = 0;
	logic low_run = 1'b0;
	logic expect_valid = 1'b0;
	logic hold_pending = 1'b0;
	logic seen_after_reset = 1'b0;
	logic hold_data, hold_first, hold_last;
	logic [CODE_N-1:0] cw_acc = '0;

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	bch_encode_top dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_data(in_data),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_first(out_first),
		.out_last(out_last),
		.out_ready(out_ready)
	);

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("Mismatch at time %0t: %s expected %0h, got %0h", $time, name, expected,
				actual);
		end
	endtask

	task automatic report_problem(input string what);
		errors++;
		$display("Error at time %0t: %s", $time, what);
	endtask

	// offers one message bit after an optional idle gap and waits until it is taken
	task automatic send_bit(input logic value, output logic ok);
		int waited;
		int gap;
		logic taken;
		gap = 0;
		if (stall_mode) begin
			rng_in = lcg_next(rng_in);
			gap = rng_in[31:30];
		end
		in_valid = 1'b0;
		repeat (gap) @(negedge clk);
		in_valid = 1'b1;
		in_data = value;
		taken = 1'b0;
		waited = 0;
		while (!taken && waited < ACCEPT_TIMEOUT) begin
			@(posedge clk);
			taken = in_ready;
			@(negedge clk);
			waited++;
		end
		in_valid = 1'b0;
		ok = taken;
		assert (taken) else report_problem("timed out waiting for in_ready");
	endtask

	task automatic wait_for_frames(input int target, output logic ok);
		int waited;
		waited = 0;
		while (frames_done < target && waited < FRAME_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		ok = (frames_done >= target);
		assert (ok) else report_problem("timed out waiting for the remaining codewords");
	endtask

	// the consumer applies random back-pressure only in the stall pass
	always @(negedge clk) begin
		if (stall_mode) begin
			rng_out = lcg_next(rng_out);
			out_ready = (rng_out[31:30] != 2'b00);
		end else begin
			out_ready = 1'b1;
		end
	end

	////////////////////////////////////////
	// monitor
	////////////////////////////////////////

	always @(posedge clk) begin : monitor
		logic [23:0] entry;
		logic [CODE_N-1:0] cw;
		logic exp_bit;
		if (!rst_n) begin
			if (reset_edges > 0) begin
				check_value("out_valid", 1'b0, out_valid);
				check_value("out_first", 1'b0, out_first);
				check_value("out_last", 1'b0, out_last);
			end
			reset_edges++;
		end else begin
			if (!seen_after_reset) begin
				check_value("out_valid", 1'b0, out_valid);
				check_value("out_first", 1'b0, out_first);
				check_value("out_last", 1'b0, out_last);
				check_value("in_ready", 1'b1, in_ready);
				seen_after_reset = 1'b1;
			end
			// a stalled beat must not change until it is taken
			if (hold_pending) begin
				check_value("out_valid", 1'b1, out_valid);
				check_value("out_data", hold_data, out_data);
				check_value("out_first", hold_first, out_first);
				check_value("out_last", hold_last, out_last);
			end
			if (expect_valid) begin
				check_value("out_valid", 1'b1, out_valid);
				expect_valid = 1'b0;
			end
			if (low_run) begin
				if (!in_ready) begin
					low_count++;
				end else begin
					check_value("in_ready low cycles", PARITY_W, low_count);
					low_run = 1'b0;
				end
			end
			if (out_valid && out_ready) begin
				assert (in_taken > 0) else
					report_problem("output beat transferred before any input was accepted");
				assert (frames_done < FRAMES * PASSES) else
					report_problem("output beat transferred after the last codeword");
				if (frames_done < FRAMES * PASSES) begin
					entry = golden[frames_done % FRAMES];
					cw = entry[CODE_N-1:0];
					if (beat_idx < MSG_K) begin
						exp_bit = entry[16 + MSG_K - 1 - beat_idx];
					end else begin
						exp_bit = cw[CODE_N-1-beat_idx];
					end
					check_value("out_data", exp_bit, out_data);
					check_value("out_first", beat_idx == 0, out_first);
					check_value("out_last", beat_idx == CODE_N - 1, out_last);
					cw_acc = {cw_acc[CODE_N-2:0], out_data};
					if (beat_idx == CODE_N - 1) begin
						check_value("codeword", cw, cw_acc);
						frames_done++;
						beat_idx = 0;
					end else begin
						beat_idx++;
					end
				end
			end
			if (in_valid && in_ready) begin
				in_taken++;
				bits_in_frame++;
				expect_valid = !stall_mode;
				if (bits_in_frame == MSG_K) begin
					bits_in_frame = 0;
					low_run = !stall_mode;
					low_count = 0;
				end
			end
			hold_pending = out_valid && !out_ready;
			hold_data = out_data;
			hold_first = out_first;
			hold_last = out_last;
		end
	end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	// the first pass runs without stalls, the second with random gaps and back-pressure
	initial begin : stimulus
		int pass;
		int f;
		int b;
		logic ok;
		logic [MSG_K-1:0] msg;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_data = 1'b0;
		out_ready = 1'b1;
		ok = 1'b1;
		$readmemh("bench/bch_golden.txt", golden);
		assert (!$isunknown(golden[FRAMES-1])) else begin
			report_problem("golden file is missing or has too few frames");
			ok = 1'b0;
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (pass = 0; pass < PASSES && ok; pass++) begin
			for (f = 0; f < FRAMES && ok; f++) begin
				msg = golden[f][16 +: MSG_K];
				for (b = MSG_K - 1; b >= 0 && ok; b--) begin
					send_bit(msg[b], ok);
				end
			end
			if (ok) begin
				wait_for_frames(FRAMES * (pass + 1), ok);
			end
			@(posedge clk);
			stall_mode <= 1'b1;
			@(negedge clk);
		end
		// idle tail so that any stray output beat is caught
		repeat (20) @(negedge clk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
logic/bch_code_pkg.sv
logic/bch_stream_pkg.sv
logic/lfsr_counter.sv
logic/parity_lfsr.sv
logic/frame_sequencer.sv
logic/codeword_mux.sv
logic/bch_encode_top.sv
bench/bch_encode_tb.sv

//--- bench/bch_golden.txt
// one frame per line: two hex digits of message, then four hex digits of codeword
// the codeword is 15 bits wide, and its bit 14 is beat 1 on the output stream
// all-zero message
000000
010537
020a6e
030f59
0411eb
0514dc
061b85
071eb2
0823d6
0926e1
0a29b8
0b2c8f
0c323d
0d370a
0e3853
0f3d64
10429b
1147ac
1248f5
134dc2
145370
155647
16591e
175c29
18614d
19647a
1a6b23
1b6e14
1c70a6
1d7591
1e7ac8
// all-one message gives the all-one codeword
1f7fff
